// File: xaui_pkg.sv
package xaui_pkg;

  localparam int num_lanes  = 4;
  localparam int lane_bytes = 2;                        // bytes per lane per clock
  localparam int word_bytes = num_lanes * lane_bytes;

  // 8b/10b and XGMII character codes
  localparam logic [7:0] char_comma  = 8'hbc;          // K28.5
  localparam logic [7:0] xgmii_idle  = 8'h07;
  localparam logic [7:0] xgmii_error = 8'hfe;
  localparam logic [7:0] xgmii_seq   = 8'h9c;
  localparam logic [7:0] xgmii_start = 8'hfb;
  localparam logic [7:0] xgmii_term  = 8'hfd;

  // local fault ordered set, one 32-bit column, lane 0 in the low byte
  localparam logic [31:0] local_fault_d = {8'h01, 8'h00, 8'h00, xgmii_seq};
  localparam logic [3:0]  local_fault_c = 4'b0001;

  // client side word, one per clock
  typedef struct packed {
    logic [63:0] d;
    logic [7:0]  c;
  } xgmii_word_t;

  // transceiver side word
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  charisk;
  } mgt_word_t;

  // per byte receive flags from the transceiver
  typedef struct packed {
    logic [7:0] code_valid;
    logic [7:0] code_comma;
  } mgt_rx_flags_t;

  // msb first, presented as link_status[7:0]
  typedef struct packed {
    logic       align_ok;
    logic [3:0] lane_sync;
    logic       rx_fault_latched;
    logic       bufferr_latched;
    logic       rxlock_ok;
  } link_status_t;

endpackage

// File: xaui_reset_stretch.sv
module xaui_reset_stretch import xaui_pkg::*; #(
  parameter int reset_stretch_cycles = 8
) (
  input  logic                 clk,
  input  logic                 mgt_rx_reset_stretch,
  input  logic [num_lanes-1:0] rxbufferr,
  output logic                 tx_reset_active,
  output logic                 rx_reset_active
);

  localparam int cnt_w = $clog2(reset_stretch_cycles + 1);
  localparam logic [cnt_w-1:0] cnt_load = cnt_w'(reset_stretch_cycles);

  logic [cnt_w-1:0] tx_cnt;
  logic [cnt_w-1:0] rx_cnt;

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch) begin
      tx_cnt <= cnt_load;
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - 1'b1;
    end
  end

  // a buffer error on any lane restarts the receive side
  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch || (rxbufferr != '0)) begin
      rx_cnt <= cnt_load;
    end else if (rx_cnt != '0) begin
      rx_cnt <= rx_cnt - 1'b1;
    end
  end

  assign tx_reset_active = (tx_cnt != '0);
  assign rx_reset_active = (rx_cnt != '0);

endmodule

// File: xaui_tx_encode.sv
module xaui_tx_encode import xaui_pkg::*; (
  input  logic        clk,
  input  logic        mgt_rx_reset_stretch,
  input  logic        tx_reset_active,
  input  xgmii_word_t txd,
  output mgt_word_t   tx_word
);

  mgt_word_t tx_next;

  always_comb begin
    tx_next = '0;
    for (int i = 0; i < word_bytes; i++) begin
      if (txd.c[i] && (txd.d[8*i +: 8] == xgmii_idle)) begin
        // idle goes out as comma so the far end keeps alignment
        tx_next.data[8*i +: 8] = char_comma;
        tx_next.charisk[i]     = 1'b1;
      end else begin
        tx_next.data[8*i +: 8] = txd.d[8*i +: 8];
        tx_next.charisk[i]     = txd.c[i];       // start, term etc keep K set
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch || tx_reset_active) begin
      tx_word.data    <= {word_bytes{char_comma}};  // all commas while in reset
      tx_word.charisk <= '1;
    end else begin
      tx_word <= tx_next;
    end
  end

endmodule

// File: xaui_lane_sync.sv
module xaui_lane_sync import xaui_pkg::*; #(
  parameter int sync_acquire_commas = 4
) (
  input  logic                  clk,
  input  logic                  mgt_rx_reset_stretch,
  input  logic                  rx_reset_active,
  input  logic [lane_bytes-1:0] code_valid,
  input  logic [lane_bytes-1:0] code_comma,
  output logic                  lane_sync
);

  localparam int cnt_w = (sync_acquire_commas > 1) ? $clog2(sync_acquire_commas) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(sync_acquire_commas - 1);

  typedef enum logic {
    st_loss,
    st_sync
  } sync_state_t;

  sync_state_t      state;
  logic [cnt_w-1:0] comma_cnt;
  logic             all_valid;
  logic             valid_comma;

  assign all_valid   = &code_valid;
  assign valid_comma = all_valid && (|code_comma);   // comma on either byte

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch || rx_reset_active) begin
      state     <= st_loss;
      comma_cnt <= '0;
    end else begin
      case (state)
        st_loss: begin
          if (!valid_comma) begin
            comma_cnt <= '0;
          end else if (comma_cnt == cnt_last) begin
            state     <= st_sync;
            comma_cnt <= '0;
          end else begin
            comma_cnt <= comma_cnt + 1'b1;
          end
        end
        default: begin
          comma_cnt <= '0;
          if (!all_valid) state <= st_loss;    // one bad code group is enough
        end
      endcase
    end
  end

  assign lane_sync = (state == st_sync);

endmodule

// File: xaui_rx_decode.sv
module xaui_rx_decode import xaui_pkg::*; (
  input  logic                 clk,
  input  logic                 mgt_rx_reset_stretch,
  input  mgt_word_t            rx_word,
  input  mgt_rx_flags_t        rx_flags,
  input  logic [num_lanes-1:0] lane_sync,
  output xgmii_word_t          rxd
);

  localparam logic [63:0] fault_d = {2{local_fault_d}};
  localparam logic [7:0]  fault_c = {2{local_fault_c}};

  xgmii_word_t decoded;
  xgmii_word_t rxd_next;
  logic        all_sync;

  assign all_sync = &lane_sync;

  // per byte decode, lane i/2 owns byte i
  always_comb begin
    decoded = '0;
    for (int i = 0; i < word_bytes; i++) begin
      if (!rx_flags.code_valid[i]) begin
        decoded.d[8*i +: 8] = xgmii_error;
        decoded.c[i]        = 1'b1;
      end else if (rx_word.charisk[i] && (rx_word.data[8*i +: 8] == char_comma)) begin
        decoded.d[8*i +: 8] = xgmii_idle;
        decoded.c[i]        = 1'b1;
      end else begin
        decoded.d[8*i +: 8] = rx_word.data[8*i +: 8];
        decoded.c[i]        = rx_word.charisk[i];
      end
    end
  end

  always_comb begin
    if (all_sync) begin
      rxd_next = decoded;
    end else begin
      // link not up, tell the client with local fault in both columns
      rxd_next.d = fault_d;
      rxd_next.c = fault_c;
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch) begin
      rxd.d <= fault_d;
      rxd.c <= fault_c;
    end else begin
      rxd <= rxd_next;
    end
  end

endmodule

// File: xaui_link_ctrl.sv
module xaui_link_ctrl import xaui_pkg::*; (
  input  logic                 clk,
  input  logic                 mgt_rx_reset_stretch,
  input  logic                 user_loopback,
  input  logic                 user_powerdown,
  input  logic [num_lanes-1:0] lane_sync,
  input  logic [num_lanes-1:0] rxlock,
  input  logic [num_lanes-1:0] syncok,
  input  logic [num_lanes-1:0] rxbufferr,
  output logic                 mgt_loopback,
  output logic                 mgt_powerdown,
  output logic [num_lanes-1:0] enable_align,
  output logic                 en_chan_sync,
  output link_status_t         status
);

  logic all_sync;

  assign all_sync = &lane_sync;

  // comma alignment only while a lane is hunting
  assign enable_align = ~lane_sync;
  assign en_chan_sync = all_sync;          // bond once every lane has sync

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch) begin
      mgt_loopback  <= 1'b0;
      mgt_powerdown <= 1'b0;
    end else begin
      mgt_loopback  <= user_loopback;
      mgt_powerdown <= user_powerdown;
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_rx_reset_stretch) begin
      status <= '0;
    end else begin
      status.align_ok  <= all_sync && (&syncok);
      status.lane_sync <= lane_sync;
      status.rxlock_ok <= &rxlock;
      // sticky until the next reset
      if (status.align_ok && !all_sync) begin
        status.rx_fault_latched <= 1'b1;
      end
      if (rxbufferr != '0) begin
        status.bufferr_latched <= 1'b1;
      end
    end
  end

endmodule

// File: xaui_controller.sv
module xaui_controller import xaui_pkg::*; #(
  parameter int reset_stretch_cycles = 8,
  parameter int sync_acquire_commas  = 4
) (
  input  logic        clk,
  input  logic        mgt_rx_reset_stretch,
  // transceiver side
  output logic [63:0] mgt_txdata,
  output logic [7:0]  mgt_txcharisk,
  input  logic [63:0] mgt_rxdata,
  input  logic [7:0]  mgt_rxcharisk,
  output logic [3:0]  mgt_enable_align,
  input  logic [7:0]  mgt_code_valid,
  input  logic [7:0]  mgt_code_comma,
  input  logic [3:0]  mgt_rxlock,
  input  logic [3:0]  mgt_rxbufferr,
  input  logic [3:0]  mgt_syncok,
  output logic        mgt_loopback,
  output logic        mgt_en_chan_sync,
  output logic        mgt_powerdown,
  output logic [3:0]  mgt_tx_reset,
  output logic [3:0]  mgt_rx_reset,
  // client side
  output logic [63:0] xgmii_rxd,
  output logic [7:0]  xgmii_rxc,
  input  logic [63:0] xgmii_txd,
  input  logic [7:0]  xgmii_txc,
  input  logic        user_loopback,
  input  logic        user_powerdown,
  output logic [7:0]  link_status
);

  xgmii_word_t          tx_client;
  mgt_word_t            tx_mgt;
  mgt_word_t            rx_mgt;
  mgt_rx_flags_t        rx_flags;
  xgmii_word_t          rx_client;
  link_status_t         status;
  logic [num_lanes-1:0] lane_sync;
  logic                 tx_reset_active;
  logic                 rx_reset_active;

  assign tx_client = '{d: xgmii_txd, c: xgmii_txc};
  assign rx_mgt    = '{data: mgt_rxdata, charisk: mgt_rxcharisk};
  assign rx_flags  = '{code_valid: mgt_code_valid, code_comma: mgt_code_comma};

  assign mgt_txdata    = tx_mgt.data;
  assign mgt_txcharisk = tx_mgt.charisk;
  assign xgmii_rxd     = rx_client.d;
  assign xgmii_rxc     = rx_client.c;
  assign link_status   = status;

  // same reset level on every lane
  assign mgt_tx_reset = {num_lanes{tx_reset_active}};
  assign mgt_rx_reset = {num_lanes{rx_reset_active}};

  xaui_reset_stretch #(
    .reset_stretch_cycles(reset_stretch_cycles)
  ) u_reset_stretch (
    .clk                 (clk),
    .mgt_rx_reset_stretch(mgt_rx_reset_stretch),
    .rxbufferr           (mgt_rxbufferr),
    .tx_reset_active     (tx_reset_active),
    .rx_reset_active     (rx_reset_active)
  );

  xaui_tx_encode u_tx_encode (
    .clk                 (clk),
    .mgt_rx_reset_stretch(mgt_rx_reset_stretch),
    .tx_reset_active     (tx_reset_active),
    .txd                 (tx_client),
    .tx_word             (tx_mgt)
  );

  for (genvar g = 0; g < num_lanes; g++) begin : g_lane
    xaui_lane_sync #(
      .sync_acquire_commas(sync_acquire_commas)
    ) u_lane_sync (
      .clk                 (clk),
      .mgt_rx_reset_stretch(mgt_rx_reset_stretch),
      .rx_reset_active     (rx_reset_active),
      .code_valid          (rx_flags.code_valid[lane_bytes*g +: lane_bytes]),
      .code_comma          (rx_flags.code_comma[lane_bytes*g +: lane_bytes]),
      .lane_sync           (lane_sync[g])
    );
  end

  xaui_rx_decode u_rx_decode (
    .clk                 (clk),
    .mgt_rx_reset_stretch(mgt_rx_reset_stretch),
    .rx_word             (rx_mgt),
    .rx_flags            (rx_flags),
    .lane_sync           (lane_sync),
    .rxd                 (rx_client)
  );

  xaui_link_ctrl u_link_ctrl (
    .clk                 (clk),
    .mgt_rx_reset_stretch(mgt_rx_reset_stretch),
    .user_loopback       (user_loopback),
    .user_powerdown      (user_powerdown),
    .lane_sync           (lane_sync),
    .rxlock              (mgt_rxlock),
    .syncok              (mgt_syncok),
    .rxbufferr           (mgt_rxbufferr),
    .mgt_loopback        (mgt_loopback),
    .mgt_powerdown       (mgt_powerdown),
    .enable_align        (mgt_enable_align),
    .en_chan_sync        (mgt_en_chan_sync),
    .status              (status)
  );

endmodule

// File: tb_xaui_controller.sv
module tb_xaui_controller;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles   = 16;
  localparam int stretch_cycles = 8;
  localparam int acquire_commas = 4;

  localparam logic [63:0] commas  = {8{8'hbc}};           // K28.5 on every byte
  localparam logic [63:0] idles   = {8{8'h07}};
  localparam logic [63:0] fault_d = {2{32'h0100_009c}};   // seq, 00, 00, 01 per column
  localparam logic [7:0]  fault_c = 8'h11;

  // one table row, stimulus first, then what the outputs must show a clock later
  typedef struct packed {
    logic [7:0]  reps;
    logic        rst;
    logic [1:0]  user;         // loopback, powerdown
    logic [3:0]  bufferr;
    logic [63:0] rxdata;
    logic [7:0]  rxk;
    logic [7:0]  valid;
    logic [7:0]  comma;
    logic [63:0] txd;
    logic [7:0]  txc;
    logic [7:0]  lock;         // rxlock, syncok
    logic [63:0] exp_txdata;
    logic [7:0]  exp_txk;
    logic [63:0] exp_rxd;
    logic [7:0]  exp_rxc;
    logic [7:0]  exp_status;
    logic [1:0]  exp_resets;   // tx, rx
    logic [3:0]  exp_align;
    logic        exp_chan;
    logic [1:0]  exp_user;
  } row_t;

  logic        clk;
  logic        mgt_rx_reset_stretch;
  logic [63:0] mgt_txdata;
  logic [7:0]  mgt_txcharisk;
  logic [63:0] mgt_rxdata;
  logic [7:0]  mgt_rxcharisk;
  logic [3:0]  mgt_enable_align;
  logic [7:0]  mgt_code_valid;
  logic [7:0]  mgt_code_comma;
  logic [3:0]  mgt_rxlock;
  logic [3:0]  mgt_rxbufferr;
  logic [3:0]  mgt_syncok;
  logic        mgt_loopback;
  logic        mgt_en_chan_sync;
  logic        mgt_powerdown;
  logic [3:0]  mgt_tx_reset;
  logic [3:0]  mgt_rx_reset;
  logic [63:0] xgmii_rxd;
  logic [7:0]  xgmii_rxc;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic        user_loopback;
  logic        user_powerdown;
  logic [7:0]  link_status;

  row_t stim_table[$];
  int   total_cycles = 0;
  int   cycle_limit  = 0;
  int   cycles       = 0;

  xaui_controller #(
    .reset_stretch_cycles(stretch_cycles),
    .sync_acquire_commas (acquire_commas)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Some tests failed");
      $fatal(1, "run did not finish in time");
    end
  end

  task automatic add_row(input row_t r);
    stim_table.push_back(r);
    total_cycles += r.reps;
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      $display("Some tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_row(input row_t r);
    mgt_rx_reset_stretch = r.rst;
    user_loopback        = r.user[1];
    user_powerdown       = r.user[0];
    mgt_rxbufferr        = r.bufferr;
    mgt_rxdata           = r.rxdata;
    mgt_rxcharisk        = r.rxk;
    mgt_code_valid       = r.valid;
    mgt_code_comma       = r.comma;
    xgmii_txd            = r.txd;
    xgmii_txc            = r.txc;
    mgt_rxlock           = r.lock[7:4];
    mgt_syncok           = r.lock[3:0];
  endtask

  task automatic check_outputs(input row_t r);
    compare_value("mgt_txdata", mgt_txdata, r.exp_txdata);
    compare_value("mgt_txcharisk", mgt_txcharisk, r.exp_txk);
    compare_value("xgmii_rxd", xgmii_rxd, r.exp_rxd);
    compare_value("xgmii_rxc", xgmii_rxc, r.exp_rxc);
    compare_value("link_status", link_status, r.exp_status);
    compare_value("mgt_tx_reset", mgt_tx_reset, {4{r.exp_resets[1]}});
    compare_value("mgt_rx_reset", mgt_rx_reset, {4{r.exp_resets[0]}});
    compare_value("mgt_enable_align", mgt_enable_align, r.exp_align);
    compare_value("mgt_en_chan_sync", mgt_en_chan_sync, r.exp_chan);
    compare_value("mgt_loopback", mgt_loopback, r.exp_user[1]);
    compare_value("mgt_powerdown", mgt_powerdown, r.exp_user[0]);
  endtask

  task automatic build_table();
    // reset, then the stretch counts down with no receive activity
    add_row({8'(reset_cycles - 1), 1'b1, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h00, 2'b11, 4'hf, 1'b0, 2'b00});
    add_row({8'(stretch_cycles - 1), 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h01, 2'b11, 4'hf, 1'b0, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h01, 2'b00, 4'hf, 1'b0, 2'b00});
    // start and data, a data 07 stays data
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, 64'h0807_0605_0403_02fb, 8'h01,
        8'hff, 64'h0807_0605_0403_02fb, 8'h01, fault_d, fault_c, 8'h01, 2'b00, 4'hf, 1'b0, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, 64'h0707_07fd_4433_2211, 8'hf0,
        8'hff, 64'hbcbc_bcfd_4433_2211, 8'hf0, fault_d, fault_c, 8'h01, 2'b00, 4'hf, 1'b0, 2'b00});
    // comma run on all lanes until sync
    add_row({8'(acquire_commas - 1), 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h01, 2'b00, 4'hf, 1'b0, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h01, 2'b00, 4'h0, 1'b1, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, idles, 8'hff, 8'hf9, 2'b00, 4'h0, 1'b1, 2'b00});
    // rxlock 3 and syncok 0 low drop rxlock_ok and align_ok for one clock
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h8877_6655_4433_22fb, 8'h01, 8'hff, 8'h00, idles, 8'hff,
        8'h7e, commas, 8'hff, 64'h8877_6655_4433_22fb, 8'h01, 8'h78, 2'b00, 4'h0, 1'b1, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'hbcbc_bcfd_4433_2211, 8'hf0, 8'hff, 8'he0, idles, 8'hff,
        8'hff, commas, 8'hff, 64'h0707_07fd_4433_2211, 8'hf0, 8'hf9, 2'b00, 4'h0, 1'b1, 2'b00});
    // byte 2 invalid, lane 1 falls out
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hfb, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, 64'h0707_0707_07fe_0707, 8'hff, 8'hf9, 2'b00, 4'h2, 1'b0, 2'b00});
    add_row({8'(acquire_commas - 1), 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h6d, 2'b00, 4'h2, 1'b0, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h6d, 2'b00, 4'h0, 1'b1, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, idles, 8'hff, 8'hfd, 2'b00, 4'h0, 1'b1, 2'b00});
    // one cycle of buffer error on lane 2
    add_row({8'd1, 1'b0, 2'b00, 4'h4, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, idles, 8'hff, 8'hff, 2'b01, 4'h0, 1'b1, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, commas, 8'hff, 8'hff, 8'hff, idles, 8'hff,
        8'hff, commas, 8'hff, idles, 8'hff, 8'hff, 2'b01, 4'hf, 1'b0, 2'b00});
    add_row({8'(stretch_cycles - 2), 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h07, 2'b01, 4'hf, 1'b0, 2'b00});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h07, 2'b00, 4'hf, 1'b0, 2'b00});
    // user controls, one clock through
    add_row({8'd1, 1'b0, 2'b10, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h07, 2'b00, 4'hf, 1'b0, 2'b10});
    add_row({8'd1, 1'b0, 2'b01, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h07, 2'b00, 4'hf, 1'b0, 2'b01});
    add_row({8'd1, 1'b0, 2'b00, 4'h0, 64'h0, 8'h00, 8'h00, 8'h00, idles, 8'hff,
        8'hff, commas, 8'hff, fault_d, fault_c, 8'h07, 2'b00, 4'hf, 1'b0, 2'b00});
  endtask

  initial begin
    mgt_rx_reset_stretch = 1'b1;
    mgt_rxdata           = '0;
    mgt_rxcharisk        = '0;
    mgt_code_valid       = '0;
    mgt_code_comma       = '0;
    mgt_rxlock           = 4'hf;   // transceiver locked at start
    mgt_rxbufferr        = '0;
    mgt_syncok           = 4'hf;
    xgmii_txd            = idles;
    xgmii_txc            = 8'hff;
    user_loopback        = 1'b0;
    user_powerdown       = 1'b0;
    build_table();
    cycle_limit = total_cycles + 1 + 64;
    @(posedge clk);
    #10;
    for (int r = 0; r < stim_table.size(); r++) begin
      for (int k = 0; k < stim_table[r].reps; k++) begin
        drive_row(stim_table[r]);
        @(posedge clk);
        #1 check_outputs(stim_table[r]);
        #9;
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// File: sources.f
xaui_pkg.sv
xaui_reset_stretch.sv
xaui_tx_encode.sv
xaui_lane_sync.sv
xaui_rx_decode.sv
xaui_link_ctrl.sv
xaui_controller.sv
tb_xaui_controller.sv

// File: Bender.yml
package:
  name: xaui_controller

sources:
  - xaui_pkg.sv
  - xaui_reset_stretch.sv
  - xaui_tx_encode.sv
  - xaui_lane_sync.sv
  - xaui_rx_decode.sv
  - xaui_link_ctrl.sv
  - xaui_controller.sv
  - target: simulation
    files:
      - tb_xaui_controller.sv
